// File: rtl/jtagDtmPkg.sv
/*
 Shared widths, codes and types for the RISC-V JTAG debug transport.
 Address width is fixed at 5 bits and data at 34 bits.
 The TAP state encoding follows the usual 0 to 15 ordering.
*/

package jtagDtmPkg;

   //------------------------------------------------------------
   // Widths
   localparam int IR_BITS        = 5;
   localparam int OP_BITS        = 2;    // Op and response code share a width
   localparam int DBUS_ADDR_BITS = 5;
   localparam int DBUS_DATA_BITS = 34;
   localparam int DBUS_REQ_BITS  = OP_BITS + DBUS_DATA_BITS + DBUS_ADDR_BITS;
   localparam int DBUS_RESP_BITS = OP_BITS + DBUS_DATA_BITS;
   localparam int DBUSRESET_BIT  = 16;   // Write-only bit in DTMINFO

   //------------------------------------------------------------
   // Types
   typedef logic [IR_BITS-1:0]        irT;
   typedef logic [OP_BITS-1:0]        opT;
   typedef logic [DBUS_ADDR_BITS-1:0] dbusAddrT;
   typedef logic [DBUS_DATA_BITS-1:0] dbusDataT;
   typedef logic [DBUS_REQ_BITS-1:0]  dbusReqT;   // {addr, data, op}
   typedef logic [DBUS_RESP_BITS-1:0] dbusRespT;  // {data, resp}
   typedef logic [31:0]               word32T;

   typedef enum logic [3:0] {
      TEST_LOGIC_RESET, RUN_TEST_IDLE, SELECT_DR, CAPTURE_DR,
      SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR,
      UPDATE_DR, SELECT_IR, CAPTURE_IR, SHIFT_IR,
      EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
   } tapStateT;

   //------------------------------------------------------------
   // Instruction codes and constants
   localparam irT IR_IDCODE  = 5'b00001;
   localparam irT IR_DTMINFO = 5'b10000;
   localparam irT IR_DBUS    = 5'b10001;
   localparam irT IR_BYPASS  = 5'b11111;   // Unknown codes act the same

   localparam word32T IDCODE_VALUE = {4'h1, 16'h0E31, 11'h489, 1'b1};
   localparam logic [3:0] DEBUG_VERSION    = 4'd0;
   localparam logic [2:0] DBUS_IDLE_CYCLES = 3'd5;   // Hint only

   localparam opT OP_NOP    = 2'b00;
   localparam opT RESP_BUSY = 2'b11;

endpackage

// File: rtl/tapController.sv
/*
 IEEE 1149.1 TAP state machine with one-hot style state strobes.
 TRST forces TEST_LOGIC_RESET asynchronously.
 Five TCK edges with TMS high reach TEST_LOGIC_RESET from any state.
*/
`timescale 1ns/10ps

module tapController
   import jtagDtmPkg::*;
(
   input  logic jtag_TCK,
   input  logic jtag_TRST,
   input  logic i_tms,
   output logic o_testLogicReset,
   output logic o_captureIr,
   output logic o_shiftIr,
   output logic o_updateIr,
   output logic o_captureDr,
   output logic o_shiftDr,
   output logic o_updateDr
);

   tapStateT tapState;
   tapStateT nextState;

   //------------------------------------------------------------
   // Transition table
   always_comb begin
      nextState = tapState;
      case (tapState)
         TEST_LOGIC_RESET: nextState = i_tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
         RUN_TEST_IDLE:    nextState = i_tms ? SELECT_DR        : RUN_TEST_IDLE;
         SELECT_DR:        nextState = i_tms ? SELECT_IR        : CAPTURE_DR;
         CAPTURE_DR:       nextState = i_tms ? EXIT1_DR         : SHIFT_DR;
         SHIFT_DR:         nextState = i_tms ? EXIT1_DR         : SHIFT_DR;
         EXIT1_DR:         nextState = i_tms ? UPDATE_DR        : PAUSE_DR;
         PAUSE_DR:         nextState = i_tms ? EXIT2_DR         : PAUSE_DR;
         EXIT2_DR:         nextState = i_tms ? UPDATE_DR        : SHIFT_DR;
         UPDATE_DR:        nextState = i_tms ? SELECT_DR        : RUN_TEST_IDLE;
         SELECT_IR:        nextState = i_tms ? TEST_LOGIC_RESET : CAPTURE_IR;
         CAPTURE_IR:       nextState = i_tms ? EXIT1_IR         : SHIFT_IR;
         SHIFT_IR:         nextState = i_tms ? EXIT1_IR         : SHIFT_IR;
         EXIT1_IR:         nextState = i_tms ? UPDATE_IR        : PAUSE_IR;
         PAUSE_IR:         nextState = i_tms ? EXIT2_IR         : PAUSE_IR;
         EXIT2_IR:         nextState = i_tms ? UPDATE_IR        : SHIFT_IR;
         UPDATE_IR:        nextState = i_tms ? SELECT_DR        : RUN_TEST_IDLE;
         default:          nextState = TEST_LOGIC_RESET;
      endcase
   end

   always_ff @(posedge jtag_TCK or posedge jtag_TRST) begin
      if (jtag_TRST) begin
         tapState <= TEST_LOGIC_RESET;
      end else begin
         tapState <= nextState;
      end
   end

   //------------------------------------------------------------
   // State strobes
   assign o_testLogicReset = (tapState == TEST_LOGIC_RESET);
   assign o_captureIr      = (tapState == CAPTURE_IR);
   assign o_shiftIr        = (tapState == SHIFT_IR);
   assign o_updateIr       = (tapState == UPDATE_IR);
   assign o_captureDr      = (tapState == CAPTURE_DR);
   assign o_shiftDr        = (tapState == SHIFT_DR);
   assign o_updateDr       = (tapState == UPDATE_DR);

   // X on TMS would otherwise spread silently into every strobe
   stateKnown: assert property (@(posedge jtag_TCK) disable iff (jtag_TRST)
      !$isunknown(tapState));

endmodule

// File: rtl/instructionReg.sv
/*
 5-bit instruction register, loaded on the falling edge of TCK.
 Returns to IDCODE in TEST_LOGIC_RESET and at TRST.
 Unknown codes select BYPASS, which is all selects low.
*/
`timescale 1ns/10ps

module instructionReg
   import jtagDtmPkg::*;
(
   input  logic    jtag_TCK,
   input  logic    jtag_TRST,
   input  logic    i_testLogicReset,
   input  logic    i_updateIr,
   input  dbusReqT i_shiftData,
   output logic    o_selIdcode,
   output logic    o_selDtmInfo,
   output logic    o_selDbus
);

   irT irReg;

   always_ff @(negedge jtag_TCK or posedge jtag_TRST) begin
      if (jtag_TRST) begin
         irReg <= IR_IDCODE;
      end else if (i_testLogicReset) begin
         irReg <= IR_IDCODE;
      end else if (i_updateIr) begin
         irReg <= i_shiftData[IR_BITS-1:0];   // Low bits hold the shifted IR
      end
   end

   // Instruction decode
   always_comb begin
      o_selIdcode  = 1'b0;
      o_selDtmInfo = 1'b0;
      o_selDbus    = 1'b0;
      case (irReg)
         IR_IDCODE:  o_selIdcode  = 1'b1;
         IR_DTMINFO: o_selDtmInfo = 1'b1;
         IR_DBUS:    o_selDbus    = 1'b1;
         IR_BYPASS:  ;                        // Bypass register
         default:    ;
      endcase
   end

endmodule

// File: rtl/dtmShiftPath.sv
/*
 Shared capture/shift register for the IR and all data registers.
 Captures and shifts on the rising edge; TDO updates on the falling edge.
 Shorter registers use the low bits of the 41-bit shift register.
*/
`timescale 1ns/10ps

module dtmShiftPath
   import jtagDtmPkg::*;
(
   input  logic       jtag_TCK,
   input  logic       jtag_TRST,
   input  logic       i_tdi,
   input  logic       i_captureIr,
   input  logic       i_shiftIr,
   input  logic       i_captureDr,
   input  logic       i_shiftDr,
   input  logic       i_selIdcode,
   input  logic       i_selDtmInfo,
   input  logic       i_selDbus,
   input  dbusReqT    i_captureWord,
   input  logic [1:0] i_dbusStatus,
   output dbusReqT    o_shiftData,
   output logic       o_tdo,
   output logic       o_tdoEnable
);

   localparam int PAD32 = DBUS_REQ_BITS - 32;

   dbusReqT shiftReg;
   word32T  dtmInfo;
   dbusReqT drCapture;
   dbusReqT drShift;

   //------------------------------------------------------------
   // DTMINFO word
   assign dtmInfo = {16'b0,                   // dbusreset reads back as 0
                     3'b0,
                     DBUS_IDLE_CYCLES,
                     i_dbusStatus,
                     4'(DBUS_ADDR_BITS),
                     DEBUG_VERSION};

   // Capture source for the selected data register
   always_comb begin
      if (i_selIdcode) begin
         drCapture = {{PAD32{1'b0}}, IDCODE_VALUE};
      end else if (i_selDtmInfo) begin
         drCapture = {{PAD32{1'b0}}, dtmInfo};
      end else if (i_selDbus) begin
         drCapture = i_captureWord;
      end else begin
         drCapture = '0;                      // Bypass
      end
   end

   // TDI entry point depends on register length
   always_comb begin
      if (i_selIdcode || i_selDtmInfo) begin
         drShift = {{PAD32{1'b0}}, i_tdi, shiftReg[31:1]};
      end else if (i_selDbus) begin
         drShift = {i_tdi, shiftReg[DBUS_REQ_BITS-1:1]};
      end else begin
         drShift = {{(DBUS_REQ_BITS-1){1'b0}}, i_tdi};   // One-bit bypass
      end
   end

   //------------------------------------------------------------
   // Shift register
   always_ff @(posedge jtag_TCK or posedge jtag_TRST) begin
      if (jtag_TRST) begin
         shiftReg <= '0;
      end else begin
         if (i_captureIr) begin
            shiftReg <= {{(DBUS_REQ_BITS-1){1'b0}}, 1'b1};
         end else if (i_shiftIr) begin
            shiftReg <= {{(DBUS_REQ_BITS-IR_BITS){1'b0}}, i_tdi, shiftReg[IR_BITS-1:1]};
         end else if (i_captureDr) begin
            shiftReg <= drCapture;
         end else if (i_shiftDr) begin
            shiftReg <= drShift;
         end
      end
   end

   assign o_shiftData = shiftReg;

   //------------------------------------------------------------
   // TDO and its output enable
   always_ff @(negedge jtag_TCK or posedge jtag_TRST) begin
      if (jtag_TRST) begin
         o_tdo       <= 1'b0;
         o_tdoEnable <= 1'b0;
      end else if (i_shiftIr || i_shiftDr) begin
         o_tdo       <= shiftReg[0];
         o_tdoEnable <= 1'b1;
      end else begin
         o_tdo       <= 1'b0;           // Quiet outside shift states
         o_tdoEnable <= 1'b0;
      end
   end

endmodule

// File: rtl/dbusAccess.sv
/*
 Debug bus access logic with busy and sticky error tracking.
 Only one transaction may be in flight. The debug module must hold
 its response until it is taken in CAPTURE_DR, and must treat a request
 as accepted only at an edge outside UPDATE_DR.
*/
`timescale 1ns/10ps

module dbusAccess
   import jtagDtmPkg::*;
(
   input  logic       jtag_TCK,
   input  logic       jtag_TRST,
   input  logic       i_captureDr,
   input  logic       i_updateDr,
   input  logic       i_selDbus,
   input  logic       i_selDtmInfo,
   input  dbusReqT    i_shiftData,
   input  logic       i_dmReqReady,
   input  logic       i_dmRespValid,
   input  dbusRespT   i_dmRespBits,
   output dbusReqT    o_captureWord,
   output logic [1:0] o_dbusStatus,
   output logic       o_dmReqValid,
   output dbusReqT    o_dmReqBits,
   output logic       o_dmRespReady
);

   logic busyReg;          // Request sent and no response taken yet
   logic stickyBusy;
   logic stickyErr;
   logic skipOp;           // Decided in CAPTURE_DR, used in UPDATE_DR
   logic downgradeOp;
   logic busy;
   logic nonzeroResp;
   logic dbusReset;

   dbusAddrT reqAddr;
   dbusDataT respData;
   opT       respCode;

   //------------------------------------------------------------
   // Decision terms, meaningful in CAPTURE_DR only
   assign respCode    = i_dmRespBits[OP_BITS-1:0];
   assign respData    = i_dmRespBits[DBUS_RESP_BITS-1:OP_BITS];
   assign reqAddr     = o_dmReqBits[DBUS_REQ_BITS-1 -: DBUS_ADDR_BITS];
   assign busy        = (busyReg & ~i_dmRespValid) | stickyBusy;
   assign nonzeroResp = (i_dmRespValid & (|respCode)) | stickyErr;
   assign dbusReset   = i_shiftData[DBUSRESET_BIT];

   assign o_captureWord = busy ? {{(DBUS_REQ_BITS-OP_BITS){1'b0}}, RESP_BUSY}
                               : {reqAddr, respData, respCode};
   assign o_dbusStatus  = {stickyErr, stickyErr | stickyBusy};
   assign o_dmRespReady = i_captureDr & i_selDbus & i_dmRespValid;

   //------------------------------------------------------------
   // Outstanding request tracking
   always_ff @(posedge jtag_TCK or posedge jtag_TRST) begin
      if (jtag_TRST) begin
         busyReg <= 1'b0;
      end else if (o_dmReqValid) begin
         busyReg <= 1'b1;
      end else if (o_dmRespReady) begin
         busyReg <= 1'b0;     // Response taken in CAPTURE_DR
      end
   end

   // Skip, downgrade and sticky flags
   always_ff @(posedge jtag_TCK or posedge jtag_TRST) begin
      if (jtag_TRST) begin
         skipOp      <= 1'b0;
         downgradeOp <= 1'b0;
         stickyBusy  <= 1'b0;
         stickyErr   <= 1'b0;
      end else if (i_selDbus) begin
         if (i_captureDr) begin
            skipOp      <= busy;
            downgradeOp <= ~busy & nonzeroResp;
            stickyBusy  <= busy;
            stickyErr   <= nonzeroResp;
         end else if (i_updateDr) begin
            skipOp      <= 1'b0;
            downgradeOp <= 1'b0;
         end
      end else if (i_selDtmInfo && i_updateDr && dbusReset) begin
         stickyBusy <= 1'b0;                  // dbusreset
         stickyErr  <= 1'b0;
      end
   end

   //------------------------------------------------------------
   // Request register
   always_ff @(posedge jtag_TCK or posedge jtag_TRST) begin
      if (jtag_TRST) begin
         o_dmReqValid <= 1'b0;
         o_dmReqBits  <= '0;
      end else if (i_updateDr) begin
         if (i_selDbus && !skipOp) begin
            o_dmReqValid <= 1'b1;
            o_dmReqBits  <= downgradeOp ? {dbusAddrT'(0), dbusDataT'(0), OP_NOP}
                                        : i_shiftData;
         end
      end else if (i_dmReqReady) begin
         o_dmReqValid <= 1'b0;
      end
   end

   reqStable: assert property (@(posedge jtag_TCK) disable iff (jtag_TRST)
      o_dmReqValid && !i_dmReqReady |=> o_dmReqValid && $stable(o_dmReqBits));

   // A response is only taken for a request that was sent
   respForRequest: assert property (@(posedge jtag_TCK) disable iff (jtag_TRST)
      o_dmRespReady |-> busyReg);

endmodule

// File: rtl/jtagDtm.sv
/*
 RISC-V JTAG debug transport module, top level.
 Debug bus request and response run on jtag_TCK with valid/ready.
 o_tdoEnable drives an external tri-state buffer for TDO.
*/
`timescale 1ns/10ps

module jtagDtm
   import jtagDtmPkg::*;
(
   input  logic     jtag_TCK,
   input  logic     jtag_TRST,
   input  logic     i_tms,
   input  logic     i_tdi,
   output logic     o_tdo,
   output logic     o_tdoEnable,
   output logic     o_dmReqValid,
   input  logic     i_dmReqReady,
   output dbusReqT  o_dmReqBits,
   input  logic     i_dmRespValid,
   output logic     o_dmRespReady,
   input  dbusRespT i_dmRespBits
);

   // TAP strobes
   logic testLogicReset;
   logic captureIr;
   logic shiftIr;
   logic updateIr;
   logic captureDr;
   logic shiftDr;
   logic updateDr;

   // Register selects
   logic selIdcode;
   logic selDtmInfo;
   logic selDbus;

   dbusReqT    shiftData;
   dbusReqT    captureWord;
   logic [1:0] dbusStatus;

   //------------------------------------------------------------
   tapController tapCtrl_i (
      .jtag_TCK        (jtag_TCK),
      .jtag_TRST       (jtag_TRST),
      .i_tms           (i_tms),
      .o_testLogicReset(testLogicReset),
      .o_captureIr     (captureIr),
      .o_shiftIr       (shiftIr),
      .o_updateIr      (updateIr),
      .o_captureDr     (captureDr),
      .o_shiftDr       (shiftDr),
      .o_updateDr      (updateDr)
   );

   instructionReg instrReg_i (
      .jtag_TCK        (jtag_TCK),
      .jtag_TRST       (jtag_TRST),
      .i_testLogicReset(testLogicReset),
      .i_updateIr      (updateIr),
      .i_shiftData     (shiftData),
      .o_selIdcode     (selIdcode),
      .o_selDtmInfo    (selDtmInfo),
      .o_selDbus       (selDbus)
   );

   dtmShiftPath shiftPath_i (
      .jtag_TCK     (jtag_TCK),
      .jtag_TRST    (jtag_TRST),
      .i_tdi        (i_tdi),
      .i_captureIr  (captureIr),
      .i_shiftIr    (shiftIr),
      .i_captureDr  (captureDr),
      .i_shiftDr    (shiftDr),
      .i_selIdcode  (selIdcode),
      .i_selDtmInfo (selDtmInfo),
      .i_selDbus    (selDbus),
      .i_captureWord(captureWord),
      .i_dbusStatus (dbusStatus),
      .o_shiftData  (shiftData),
      .o_tdo        (o_tdo),
      .o_tdoEnable  (o_tdoEnable)
   );

   dbusAccess dbusAccess_i (
      .jtag_TCK     (jtag_TCK),
      .jtag_TRST    (jtag_TRST),
      .i_captureDr  (captureDr),
      .i_updateDr   (updateDr),
      .i_selDbus    (selDbus),
      .i_selDtmInfo (selDtmInfo),
      .i_shiftData  (shiftData),
      .i_dmReqReady (i_dmReqReady),
      .i_dmRespValid(i_dmRespValid),
      .i_dmRespBits (i_dmRespBits),
      .o_captureWord(captureWord),
      .o_dbusStatus (dbusStatus),
      .o_dmReqValid (o_dmReqValid),
      .o_dmReqBits  (o_dmReqBits),
      .o_dmRespReady(o_dmRespReady)
   );

endmodule

// File: tests/jtagDtmTb.sv
/*
 Testbench for the JTAG debug transport. TMS and TDI change on the
 falling edge, TDO is sampled on the rising edge. The TAP rests in
 RUN_TEST_IDLE between scans while the debug-module side is served.
*/
`timescale 1ns/10ps

module jtagDtmTb
   import jtagDtmPkg::*;
();

   localparam int     TIMEOUT    = 200;
   localparam word32T EXP_IDCODE = {4'h1, 16'h0E31, 11'h489, 1'b1};

   logic     jtag_TCK;
   logic     jtag_TRST;
   logic     tms;
   logic     tdi;
   logic     tdo;
   logic     tdoEnable;
   logic     dmReqValid;
   logic     dmReqReady;
   dbusReqT  dmReqBits;
   logic     dmRespValid;
   logic     dmRespReady;
   dbusRespT dmRespBits;

   logic [31:0] rngState;
   int          errors;
   int          checks;

   // Reference model
   irT       mIr;
   logic     mBusyOut;        // Request sent, response not yet taken
   logic     mStickyBusy;
   logic     mStickyErr;
   dbusAddrT mLastAddr;
   dbusReqT  mReq;            // Last request the DUT should have sent

   // Debug-module side seen in CAPTURE_DR
   logic     capRespValid;
   logic     capRespReady;
   dbusRespT capRespBits;

   always #2 jtag_TCK = ~jtag_TCK;

   jtagDtm dut_i (
      .jtag_TCK     (jtag_TCK),
      .jtag_TRST    (jtag_TRST),
      .i_tms        (tms),
      .i_tdi        (tdi),
      .o_tdo        (tdo),
      .o_tdoEnable  (tdoEnable),
      .o_dmReqValid (dmReqValid),
      .i_dmReqReady (dmReqReady),
      .o_dmReqBits  (dmReqBits),
      .i_dmRespValid(dmRespValid),
      .o_dmRespReady(dmRespReady),
      .i_dmRespBits (dmRespBits)
   );

   //------------------------------------------------------------
   // Random numbers and compare tasks
   function automatic logic [31:0] nextRand();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic dbusReqT randReq();
      return dbusReqT'({nextRand(), nextRand()});
   endfunction

   function automatic logic [1:0] modelStatus();
      return {mStickyErr, mStickyErr | mStickyBusy};
   endfunction

   task automatic checkWord(input string name, input word32T exp, input word32T act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic checkReq(input string name, input dbusReqT exp, input dbusReqT act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic checkIr(input string name, input irT exp, input irT act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic checkStatus(input string name, input logic [1:0] exp, input logic [1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic checkFlag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic reportTimeout(input string what);
      errors++;
      $display("Timed out waiting for %s", what);
   endtask

   //------------------------------------------------------------
   // JTAG scans, each starting and ending in RUN_TEST_IDLE
   task automatic tmsStep(input logic value);
      @(negedge jtag_TCK);
      tms = value;
   endtask

   task automatic shiftScan(input logic isIr, input int n, input dbusReqT din,
                            output dbusReqT dout);
      dout = '0;
      tmsStep(1'b1);                          // SELECT_DR
      if (isIr)
         tmsStep(1'b1);                       // SELECT_IR
      tmsStep(1'b0);                          // Capture state next
      tmsStep(1'b0);
      capRespValid = dmRespValid;             // Now in the capture state
      capRespReady = dmRespReady;
      capRespBits  = dmRespBits;
      checkFlag("tdoEnable before shift", 1'b0, tdoEnable);
      for (int i = 0; i < n; i++) begin
         @(negedge jtag_TCK);
         tdi = din[i];
         tms = (i == n - 1);
         if (i == 0 && capRespReady)
            dmRespValid = 1'b0;               // Response consumed
         @(posedge jtag_TCK);
         dout[i] = tdo;
         checkFlag("tdoEnable in shift", 1'b1, tdoEnable);
      end
      tmsStep(1'b1);                          // UPDATE
      tmsStep(1'b0);                          // RUN_TEST_IDLE
      tmsStep(1'b0);
      checkFlag("tdoEnable after shift", 1'b0, tdoEnable);
   endtask

   task automatic irScan(input irT din, input string name);
      dbusReqT dout;
      shiftScan(1'b1, 5, dbusReqT'(din), dout);
      checkIr(name, 5'b00001, irT'(dout));
      mIr = din;
   endtask

   task automatic drScan(input dbusReqT din, input string name);
      dbusReqT    dout;
      dbusReqT    exp;
      word32T     info;
      logic       busyNow;
      logic       nonzero;
      case (mIr)
         IR_IDCODE: begin
            shiftScan(1'b0, 32, din, dout);
            checkWord(name, EXP_IDCODE, word32T'(dout));
         end
         IR_DTMINFO: begin
            info = {19'b0, 3'd5, modelStatus(), 4'd5, 4'd0};
            shiftScan(1'b0, 32, din, dout);
            checkWord(name, info, word32T'(dout));
            checkStatus({name, " status"}, modelStatus(), dout[9:8]);
            if (din[16]) begin                // dbusreset
               mStickyBusy = 1'b0;
               mStickyErr  = 1'b0;
            end
         end
         IR_DBUS: begin
            shiftScan(1'b0, 41, din, dout);
            busyNow = (mBusyOut && !capRespValid) || mStickyBusy;
            nonzero = (capRespValid && capRespBits[1:0] != 2'b00) || mStickyErr;
            exp     = busyNow ? dbusReqT'(2'b11) : {mLastAddr, capRespBits};
            checkReq(name, exp, dout);
            checkFlag({name, " respReady"}, capRespValid, capRespReady);
            if (capRespValid)
               mBusyOut = 1'b0;
            mStickyBusy = busyNow;
            mStickyErr  = nonzero;
            if (!busyNow) begin
               mReq      = nonzero ? '0 : din;   // Downgrade to NOP
               mLastAddr = mReq[40:36];
               mBusyOut  = 1'b1;
            end
            checkFlag({name, " reqValid"}, !busyNow, dmReqValid);
         end
         default: begin                       // Bypass, one bit of delay
            shiftScan(1'b0, 41, din, dout);
            checkReq(name, {din[39:0], 1'b0}, dout);
         end
      endcase
   endtask

   task automatic tmsReset();
      repeat (5) tmsStep(1'b1);
      tmsStep(1'b0);
      tmsStep(1'b0);
      mIr = IR_IDCODE;
   endtask

   //------------------------------------------------------------
   // Debug-module responder
   task automatic respond(input opT code);
      @(negedge jtag_TCK);
      dmRespBits  = {dbusDataT'({nextRand(), nextRand()}), code};
      dmRespValid = 1'b1;
   endtask

   task automatic serveRequest(input opT code, input logic answer);
      int tmo;
      checkReq("request bits", mReq, dmReqBits);
      repeat (nextRand() % 4) @(negedge jtag_TCK);
      dmReqReady = 1'b1;
      tmo = 0;
      do begin
         @(negedge jtag_TCK);
         tmo++;
      end while (dmReqValid && tmo < TIMEOUT);
      dmReqReady = 1'b0;
      if (dmReqValid) begin
         reportTimeout("request acceptance");
      end else if (answer) begin
         repeat (nextRand() % 5) @(negedge jtag_TCK);
         respond(code);
      end
   endtask

   //------------------------------------------------------------
   initial begin
      jtag_TCK    = 1'b0;
      jtag_TRST   = 1'b1;
      tms         = 1'b1;
      tdi         = 1'b0;
      dmReqReady  = 1'b0;
      dmRespValid = 1'b0;
      dmRespBits  = '0;
      rngState    = 32'hf00c_cfc7;
      errors      = 0;
      checks      = 0;
      mIr         = IR_IDCODE;
      mBusyOut    = 1'b0;
      mStickyBusy = 1'b0;
      mStickyErr  = 1'b0;
      mLastAddr   = '0;
      mReq        = '0;
      repeat (5) @(negedge jtag_TCK);
      jtag_TRST = 1'b0;
      checkFlag("reqValid after reset", 1'b0, dmReqValid);
      checkFlag("tdo after reset", 1'b0, tdo);
      tmsStep(1'b0);
      tmsStep(1'b0);

      drScan(randReq(), "idcode after reset");
      irScan(IR_DBUS, "ir capture");
      tmsReset();
      drScan(randReq(), "idcode after tms reset");

      irScan(IR_BYPASS, "ir capture");
      drScan(randReq(), "bypass");
      irScan(5'b00110, "ir capture");          // Unknown code
      drScan(randReq(), "unknown as bypass");

      irScan(IR_DTMINFO, "ir capture");
      drScan('0, "dtminfo");

      irScan(IR_DBUS, "ir capture");
      for (int i = 0; i < 8; i++) begin
         drScan(randReq(), "dbus op");
         serveRequest(2'b00, 1'b1);
      end

      // Held response gives busy, then dbusreset
      drScan(randReq(), "dbus op");
      serveRequest(2'b00, 1'b0);
      drScan(randReq(), "dbus while busy");
      respond(2'b00);
      irScan(IR_DTMINFO, "ir capture");
      drScan('0, "dtminfo busy");
      drScan(dbusReqT'(1) << 16, "dtminfo dbusreset");
      drScan('0, "dtminfo cleared");
      irScan(IR_DBUS, "ir capture");
      drScan(randReq(), "dbus after busy");
      serveRequest(2'b00, 1'b1);

      // Error response downgrades the next op
      drScan(randReq(), "dbus op");
      serveRequest(2'b10, 1'b1);
      drScan(randReq(), "dbus error");
      serveRequest(2'b00, 1'b1);
      irScan(IR_DTMINFO, "ir capture");
      drScan('0, "dtminfo error");
      drScan(dbusReqT'(1) << 16, "dtminfo dbusreset");
      drScan('0, "dtminfo cleared");
      irScan(IR_DBUS, "ir capture");
      drScan(randReq(), "dbus after error");
      serveRequest(2'b00, 1'b1);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// File: jtagDtm.f
rtl/jtagDtmPkg.sv
rtl/tapController.sv
rtl/instructionReg.sv
rtl/dtmShiftPath.sv
rtl/dbusAccess.sv
rtl/jtagDtm.sv
tests/jtagDtmTb.sv

// File: run.sh
#!/bin/sh
# Build and run the JTAG DTM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f jtagDtm.f --top-module jtagDtmTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/VjtagDtmTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
   exit 0
fi
exit 1
